// ==== build.f ====
+incdir+source
source/conv_pkg.sv
source/conv_cmd_if.sv
source/conv_decoder.sv
source/conv_operand_buffer.sv
source/conv_mac_sequencer.sv
source/conv_accel_top.sv
testbench/conv_tb_assertions.sv
testbench/conv_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the convolution accelerator testbench with Verilator
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module conv_tb \
    -o conv_sim > build.log 2>&1 \
    && ./obj_dir/conv_sim +verilator+error+limit+1000 > sim.log 2>&1 \
    || echo "RESULT: FAIL" >> sim.log
cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1 || exit 0

// ==== testbench/conv_tb.sv ====
`timescale 1ns/1ns

`include "conv_settings.svh"

module conv_tb;

    localparam int clk_period = 20;
    localparam int max_instr  = 160;  // upper bound on issued instructions

    localparam logic [2:0] f3_load_filter  = 3'd0;
    localparam logic [2:0] f3_load_data    = 3'd1;
    localparam logic [2:0] f3_clear_filter = 3'd2;
    localparam logic [2:0] f3_clear_data   = 3'd3;
    localparam logic [2:0] f3_run          = 3'd4;

    logic            clk_i = 1'b0;
    logic            rst_i;
    logic            hold_i;
    logic            instr_valid_i;
    logic [31:0]     instr_i;
    conv_pkg::word_t rs1_data_i;
    conv_pkg::word_t rs2_data_i;
    conv_pkg::word_t result_o;
    logic            result_valid_o;
    logic            stall_o;
    integer          seed;
    int              k;

    conv_accel_top uut (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .hold_i         (hold_i),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .rs1_data_i     (rs1_data_i),
        .rs2_data_i     (rs2_data_i),
        .result_o       (result_o),
        .result_valid_o (result_valid_o),
        .stall_o        (stall_o)
    );

    bind conv_accel_top conv_tb_assertions chk (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .hold_i         (hold_i),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .rs1_data_i     (rs1_data_i),
        .rs2_data_i     (rs2_data_i),
        .result_o       (result_o),
        .result_valid_o (result_valid_o),
        .stall_o        (stall_o)
    );

    always #(clk_period / 2) clk_i = ~clk_i;

    function automatic logic [31:0] encode(input logic [2:0] funct3, input logic pair);
        return {6'd0, pair, 10'd0, funct3, 5'd0, `CONV_OPCODE};
    endfunction

    task automatic issue(input logic [2:0] funct3, input logic pair,
                         input conv_pkg::word_t w0, input conv_pkg::word_t w1);
        @(posedge clk_i);
        instr_valid_i <= 1'b1;
        instr_i       <= encode(funct3, pair);
        rs1_data_i    <= w0;
        rs2_data_i    <= w1;
    endtask

    task automatic idle(input int n);
        @(posedge clk_i);
        instr_valid_i <= 1'b0;
        repeat (n - 1) @(posedge clk_i);
    endtask

    task automatic load_random(input logic [2:0] funct3, input int count, input logic pair);
        for (int i = 0; i < count; i++) begin
            issue(funct3, pair, $random(seed), $random(seed));
        end
    endtask

    task automatic clear_both();
        issue(f3_clear_filter, 1'b0, '0, '0);
        issue(f3_clear_data, 1'b0, '0, '0);
    endtask

    // run is held until the result pulse, hold optionally raised after the run is seen
    task automatic run_and_wait(input int hold_cycles);
        issue(f3_run, 1'b0, '0, '0);
        if (hold_cycles > 0) begin
            @(posedge clk_i);
            hold_i <= 1'b1;
            repeat (hold_cycles) @(posedge clk_i);
            hold_i <= 1'b0;
        end
        do @(posedge clk_i); while (!result_valid_o);
        instr_valid_i <= 1'b0;
    endtask

    // first assertion failure ends the run
    always @(posedge clk_i) begin
        if (uut.chk.fail_flag) begin
            $display("ERR %0t: %s", $time, uut.chk.fail_msg);
            $display("RESULT: FAIL");
            $fatal(1, "assertion failed");
        end
    end

    initial begin
        #(max_instr * 40 * clk_period);
        $display("watchdog: the simulation did not finish in time");
        $display("RESULT: FAIL");
        $fatal(1, "timeout");
    end

    initial begin
        seed          = 32'hc3ee;
        rst_i         = 1'b0;
        hold_i        = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        rs1_data_i    = '0;
        rs2_data_i    = '0;
        repeat (16) @(posedge clk_i);
        rst_i <= 1'b1;
        idle(5);

        // full buffers, single loads
        load_random(f3_load_filter, 16, 1'b0);
        load_random(f3_load_data, 16, 1'b0);
        run_and_wait(0);
        idle(2);

        // paired loads interleaved, then loads while locked
        clear_both();
        for (int i = 0; i < 8; i++) begin
            load_random(f3_load_filter, 1, 1'b1);
            load_random(f3_load_data, 1, 1'b1);
        end
        run_and_wait(0);
        load_random(f3_load_data, 2, 1'b0);
        run_and_wait(0);
        // new filter over the kept data buffer
        issue(f3_clear_filter, 1'b0, '0, '0);
        load_random(f3_load_filter, 16, 1'b0);
        run_and_wait(0);
        idle(2);

        // partial fill
        clear_both();
        k = 1 + (($random(seed) & 32'h7fff_ffff) % 15);
        load_random(f3_load_filter, k, 1'b0);
        load_random(f3_load_data, k, 1'b0);
        run_and_wait(0);
        idle(2);

        // new data with kept filter
        issue(f3_clear_data, 1'b0, '0, '0);
        load_random(f3_load_data, 16, 1'b0);
        run_and_wait(0);
        idle(2);

        // hold during a pending run
        clear_both();
        for (int i = 0; i < 8; i++) begin
            load_random(f3_load_filter, 1, 1'b1);
            load_random(f3_load_data, 1, 1'b1);
        end
        run_and_wait(6);
        idle(4);

        if (uut.chk.fail_flag) begin
            $display("ERR %0t: %s", $time, uut.chk.fail_msg);
            $display("RESULT: FAIL");
            $fatal(1, "assertion failed");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

// ==== testbench/conv_tb_assertions.sv ====
`timescale 1ns/1ns

`include "conv_settings.svh"

module conv_tb_assertions (
    input logic            clk_i,
    input logic            rst_i,
    input logic            hold_i,
    input logic            instr_valid_i,
    input logic [31:0]     instr_i,
    input conv_pkg::word_t rs1_data_i,
    input conv_pkg::word_t rs2_data_i,
    input conv_pkg::word_t result_o,
    input logic            result_valid_o,
    input logic            stall_o
);

    conv_pkg::word_t      f_words [`CONV_DEPTH];
    conv_pkg::word_t      d_words [`CONV_DEPTH];
    conv_pkg::slot_idx_t  f_idx;
    conv_pkg::slot_idx_t  d_idx;
    conv_pkg::fill_mask_t f_mask;
    conv_pkg::fill_mask_t d_mask;
    conv_pkg::word_t      expected;
    logic                 seen_instr;
    logic                 locked;
    logic                 is_accel;
    logic [2:0]           f3;
    logic                 pair;
    logic                 fail_flag = 1'b0;
    string                fail_msg = "";

    assign is_accel = instr_valid_i && (instr_i[6:0] == `CONV_OPCODE);
    assign f3       = instr_i[14:12];
    assign pair     = instr_i[25];
    assign locked   = (&f_mask) && (&d_mask); // all slots summed, loads dropped

    // dot product over the leading slots filled in both buffers
    always_comb begin
        logic run_on;
        run_on   = 1'b1;
        expected = '0;
        for (int i = 0; i < `CONV_DEPTH; i++) begin
            if (!(f_mask[i] && d_mask[i])) run_on = 1'b0;
            if (run_on) expected = expected + f_words[i] * d_words[i];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            f_idx      <= '0;
            d_idx      <= '0;
            f_mask     <= '0;
            d_mask     <= '0;
            seen_instr <= 1'b0;
        end else begin
            if (instr_valid_i) seen_instr <= 1'b1;
            if (is_accel && f3 == 3'd0 && !locked) begin
                f_words[f_idx] <= rs1_data_i;
                f_mask[f_idx]  <= 1'b1;
                if (pair) begin
                    f_words[conv_pkg::slot_idx_t'(f_idx + 1)] <= rs2_data_i;
                    f_mask[conv_pkg::slot_idx_t'(f_idx + 1)]  <= 1'b1;
                end
                f_idx <= conv_pkg::slot_idx_t'(f_idx + (pair ? 2 : 1));
            end
            if (is_accel && f3 == 3'd1 && !locked) begin
                d_words[d_idx] <= rs1_data_i;
                d_mask[d_idx]  <= 1'b1;
                if (pair) begin
                    d_words[conv_pkg::slot_idx_t'(d_idx + 1)] <= rs2_data_i;
                    d_mask[conv_pkg::slot_idx_t'(d_idx + 1)]  <= 1'b1;
                end
                d_idx <= conv_pkg::slot_idx_t'(d_idx + (pair ? 2 : 1));
            end
            if (is_accel && f3 == 3'd2) begin
                f_idx  <= '0;
                f_mask <= '0;
            end
            if (is_accel && f3 == 3'd3) begin
                d_idx  <= '0;
                d_mask <= '0;
            end
        end
    end

    a_quiet_after_reset: assert property (@(posedge clk_i) disable iff (!rst_i)
        !seen_instr |-> (!stall_o && !result_valid_o))
    else begin
        fail_msg  = "stall or result valid before any instruction";
        fail_flag = 1'b1;
        $error("activity before first instruction");
    end

    a_no_stall_on_result: assert property (@(posedge clk_i) disable iff (!rst_i)
        result_valid_o |-> !stall_o)
    else begin
        fail_msg  = "stall high together with result valid";
        fail_flag = 1'b1;
        $error("stall during result");
    end

    a_result_value: assert property (@(posedge clk_i) disable iff (!rst_i)
        result_valid_o |-> (result_o == expected))
    else begin
        fail_msg  = $sformatf("result %h, expected %h", result_o, expected);
        fail_flag = 1'b1;
        $error("wrong result");
    end

    a_single_pulse: assert property (@(posedge clk_i) disable iff (!rst_i)
        result_valid_o |=> (!result_valid_o && !stall_o))
    else begin
        fail_msg  = "result valid or stall high in the cycle after a result";
        fail_flag = 1'b1;
        $error("result not a single pulse");
    end

    a_hold_blocks_result: assert property (@(posedge clk_i) disable iff (!rst_i)
        hold_i |-> !result_valid_o)
    else begin
        fail_msg  = "result valid while hold is high";
        fail_flag = 1'b1;
        $error("result during hold");
    end

endmodule

// ==== source/conv_accel_top.sv ====
`timescale 1ns/1ns

module conv_accel_top (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            hold_i,
    input  logic            instr_valid_i,
    input  logic [31:0]     instr_i,
    input  conv_pkg::word_t rs1_data_i,
    input  conv_pkg::word_t rs2_data_i,
    output conv_pkg::word_t result_o,
    output logic            result_valid_o,
    output logic            stall_o
);

    conv_pkg::fill_mask_t filter_mask;
    conv_pkg::fill_mask_t data_mask;
    conv_pkg::word_t      filter_word;
    conv_pkg::word_t      data_word;
    conv_pkg::slot_idx_t  rd_idx;
    logic                 run_ready;

    conv_cmd_if cmd_bus ();

    conv_decoder decoder (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .hold_i         (hold_i),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .rs1_data_i     (rs1_data_i),
        .rs2_data_i     (rs2_data_i),
        .run_ready_i    (run_ready),
        .stall_o        (stall_o),
        .result_valid_o (result_valid_o),
        .cmd            (cmd_bus.decoder)
    );

    conv_operand_buffer #(.role(conv_pkg::kind_filter)) filter_buf (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .cmd         (cmd_bus.sink),
        .rd_idx_i    (rd_idx),
        .rd_data_o   (filter_word),
        .fill_mask_o (filter_mask)
    );

    conv_operand_buffer #(.role(conv_pkg::kind_data)) data_buf (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .cmd         (cmd_bus.sink),
        .rd_idx_i    (rd_idx),
        .rd_data_o   (data_word),
        .fill_mask_o (data_mask)
    );

    conv_mac_sequencer sequencer (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .cmd           (cmd_bus.sink),
        .filter_mask_i (filter_mask),
        .data_mask_i   (data_mask),
        .filter_word_i (filter_word),
        .data_word_i   (data_word),
        .rd_idx_o      (rd_idx),
        .run_ready_o   (run_ready),
        .result_o      (result_o)
    );

endmodule

// ==== source/conv_mac_sequencer.sv ====
`timescale 1ns/1ns

`include "conv_settings.svh"

module conv_mac_sequencer (
    input  logic                 clk_i,
    input  logic                 rst_i,
    conv_cmd_if.sink             cmd,
    input  conv_pkg::fill_mask_t filter_mask_i,
    input  conv_pkg::fill_mask_t data_mask_i,
    input  conv_pkg::word_t      filter_word_i,
    input  conv_pkg::word_t      data_word_i,
    output conv_pkg::slot_idx_t  rd_idx_o,
    output logic                 run_ready_o,
    output conv_pkg::word_t      result_o
);

    localparam conv_pkg::slot_idx_t last_slot = conv_pkg::slot_idx_t'(`CONV_DEPTH - 1);

    conv_pkg::mac_state_t state;
    conv_pkg::slot_idx_t  idx;
    conv_pkg::slot_idx_t  idx_nxt;
    conv_pkg::word_t      acc;
    conv_pkg::word_t      product;
    conv_pkg::fill_mask_t both_filled;
    logic                 clr;
    logic                 can_add;

    // either buffer clear restarts the dot product
    assign clr = (cmd.op == conv_pkg::op_clear_filter) ||
                 (cmd.op == conv_pkg::op_clear_data);

    assign both_filled = filter_mask_i & data_mask_i;
    assign idx_nxt     = conv_pkg::slot_idx_t'(idx + 1'b1);
    assign can_add     = (state == conv_pkg::st_accumulate) && both_filled[idx];
    assign product     = filter_word_i * data_word_i; // truncated to word width

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state <= conv_pkg::st_accumulate;
            idx   <= '0;
            acc   <= '0;
        end else if (clr) begin
            state <= conv_pkg::st_accumulate;
            idx   <= '0;
            acc   <= '0;
        end else if (can_add) begin
            acc <= acc + product;
            idx <= idx_nxt;
            if (idx == last_slot) begin
                state <= conv_pkg::st_done;
            end
        end
    end

    // sum is final next cycle: done, last slot, or nothing more to add after idx
    assign run_ready_o = (state == conv_pkg::st_done) ||
                         (idx == last_slot) ||
                         !both_filled[idx_nxt];

    assign cmd.lock = (state == conv_pkg::st_done);
    assign rd_idx_o = idx;
    assign result_o = acc;

endmodule

// ==== source/conv_operand_buffer.sv ====
`timescale 1ns/1ns

`include "conv_settings.svh"

module conv_operand_buffer #(
    parameter conv_pkg::buf_kind_t role = conv_pkg::kind_filter
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    conv_cmd_if.sink               cmd,
    input  conv_pkg::slot_idx_t    rd_idx_i,
    output conv_pkg::word_t        rd_data_o,
    output conv_pkg::fill_mask_t   fill_mask_o
);

    localparam conv_pkg::conv_op_t load_op =
        (role == conv_pkg::kind_filter) ? conv_pkg::op_load_filter : conv_pkg::op_load_data;
    localparam conv_pkg::conv_op_t clear_op =
        (role == conv_pkg::kind_filter) ? conv_pkg::op_clear_filter : conv_pkg::op_clear_data;

    conv_pkg::word_t      words [`CONV_DEPTH];
    conv_pkg::slot_idx_t  wr_idx;
    conv_pkg::slot_idx_t  wr_idx_nxt;  // second slot of a pair
    conv_pkg::fill_mask_t mask;
    logic                 do_load;
    logic                 do_clear;

    assign do_clear   = (cmd.op == clear_op);
    assign do_load    = (cmd.op == load_op);
    assign wr_idx_nxt = conv_pkg::slot_idx_t'(wr_idx + 1'b1);

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            wr_idx <= '0;
            mask   <= '0;
        end else if (do_clear) begin
            wr_idx <= '0;
            mask   <= '0;
        end else if (do_load) begin
            mask[wr_idx] <= 1'b1;
            if (cmd.pair) begin
                mask[wr_idx_nxt] <= 1'b1;
                wr_idx           <= conv_pkg::slot_idx_t'(wr_idx + 2'd2);
            end else begin
                wr_idx <= wr_idx_nxt;
            end
        end
    end

    // word storage
    always_ff @(posedge clk_i) begin
        if (do_clear) begin
            for (int i = 0; i < `CONV_DEPTH; i++) begin
                words[i] <= '0;
            end
        end else if (do_load) begin
            words[wr_idx] <= cmd.word0;
            if (cmd.pair) words[wr_idx_nxt] <= cmd.word1;
        end
    end

    assign rd_data_o   = words[rd_idx_i];
    assign fill_mask_o = mask;

endmodule

// ==== source/conv_decoder.sv ====
`timescale 1ns/1ns

`include "conv_settings.svh"

module conv_decoder (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            hold_i,
    input  logic            instr_valid_i,
    input  logic [31:0]     instr_i,
    input  conv_pkg::word_t rs1_data_i,
    input  conv_pkg::word_t rs2_data_i,
    input  logic            run_ready_i,
    output logic            stall_o,
    output logic            result_valid_o,
    conv_cmd_if.decoder     cmd
);

    localparam logic [2:0] f3_load_filter  = 3'd0;
    localparam logic [2:0] f3_load_data    = 3'd1;
    localparam logic [2:0] f3_clear_filter = 3'd2;
    localparam logic [2:0] f3_clear_data   = 3'd3;
    localparam logic [2:0] f3_run          = 3'd4;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       is_accel;
    logic       run_req;
    logic       stall_q;
    logic       done_q;   // completion decided, result not yet reported
    logic       accept;
    logic       deliver;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    assign is_accel = instr_valid_i && (opcode == `CONV_OPCODE);
    assign run_req  = is_accel && (funct3 == f3_run);

    always_comb begin
        cmd.op = conv_pkg::op_none;
        if (is_accel) begin
            case (funct3)
                f3_load_filter: begin
                    if (!cmd.lock) cmd.op = conv_pkg::op_load_filter;
                end
                f3_load_data: begin
                    if (!cmd.lock) cmd.op = conv_pkg::op_load_data;
                end
                f3_clear_filter: cmd.op = conv_pkg::op_clear_filter;
                f3_clear_data:   cmd.op = conv_pkg::op_clear_data;
                f3_run:          cmd.op = conv_pkg::op_run;
                default:         cmd.op = conv_pkg::op_none;
            endcase
        end
    end

    assign cmd.pair  = funct7[0];
    assign cmd.word0 = rs1_data_i;
    assign cmd.word1 = rs2_data_i;

    // new runs are only taken outside hold
    assign accept  = run_req && !stall_q && !done_q && !hold_i;
    assign deliver = done_q && !hold_i;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            stall_q <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            if (deliver) begin
                done_q  <= 1'b0;
                stall_q <= 1'b0;
            end else if (stall_q && run_ready_i) begin
                done_q <= 1'b1; // may land inside hold, kept until it falls
            end else if (accept) begin
                if (run_ready_i) begin
                    done_q <= 1'b1;
                end else begin
                    stall_q <= 1'b1;
                end
            end
        end
    end

    assign stall_o        = stall_q && !deliver;
    assign result_valid_o = deliver && run_req;

endmodule

// ==== source/conv_cmd_if.sv ====
`timescale 1ns/1ns

// decoded command bus, decoder -> buffers and sequencer
interface conv_cmd_if;

    conv_pkg::conv_op_t op;
    logic               pair;  // second word valid
    conv_pkg::word_t    word0;
    conv_pkg::word_t    word1;
    logic               lock;  // sequencer in st_done, loads are dropped

    modport decoder (
        output op,
        output pair,
        output word0,
        output word1,
        input  lock
    );

    // only the sequencer drives lock
    modport sink (
        input  op,
        input  pair,
        input  word0,
        input  word1,
        output lock
    );

endinterface

// ==== source/conv_pkg.sv ====
`include "conv_settings.svh"

package conv_pkg;

    typedef logic [`CONV_WORD_W-1:0] word_t;
    typedef logic [$clog2(`CONV_DEPTH)-1:0] slot_idx_t; // wraps 15 -> 0
    typedef logic [`CONV_DEPTH-1:0] fill_mask_t;

    typedef enum logic [2:0] {
        op_none,
        op_load_filter,
        op_load_data,
        op_clear_filter,
        op_clear_data,
        op_run
    } conv_op_t;

    typedef enum logic {st_accumulate, st_done} mac_state_t;

    typedef enum logic {kind_filter, kind_data} buf_kind_t; // operand buffer role

endpackage

// ==== source/conv_settings.svh ====
`ifndef CONV_SETTINGS_SVH
`define CONV_SETTINGS_SVH

// slots per operand buffer
`define CONV_DEPTH 16

// operand and result width
`define CONV_WORD_W 32

// custom-0 major opcode
`define CONV_OPCODE 7'b0001011

`endif
